//--- hw/pov_defs.svh
// POV display shared constants

`ifndef POV_DEFS_SVH
`define POV_DEFS_SVH

// Driver data path geometry
`define POV_NUM_LANES    4
`define POV_WORD_BITS    16
`define POV_NUM_COLUMNS  8
`define POV_COL_BITS     3

// Flop depth for asynchronous pins (SPI, hall)
`define POV_SYNC_STAGES  2

// Lanes whose board buffer inverts, indexed by pin
`define POV_SIN_INVERT   4'b0101

// Host command opcodes
`define POV_OP_WRITE_COLUMN  8'h01
`define POV_OP_SET_MUX       8'h02
`define POV_OP_READ_STATUS   8'h03

`endif

//--- hw/pov_cmd_pkg.sv
// Host command side types

`include "pov_defs.svh"

package pov_cmd_pkg;

    // Opcode byte, OP_NONE is never sent by the host
    typedef enum logic [7:0] {
        OP_NONE         = 8'h00,
        OP_WRITE_COLUMN = `POV_OP_WRITE_COLUMN,
        OP_SET_MUX      = `POV_OP_SET_MUX,
        OP_READ_STATUS  = `POV_OP_READ_STATUS
    } cmd_opcode_e;

    // Byte stream parser position within a command
    typedef enum logic [2:0] {
        PS_OPCODE,
        PS_COLUMN,
        PS_DATA,
        PS_MASK,
        PS_STATUS,
        PS_DRAIN
    } parse_state_e;

    // One frame memory entry being assembled, words[i] feeds lane i
    typedef struct packed {
        logic [`POV_COL_BITS-1:0]                       column;
        logic [`POV_NUM_LANES-1:0][`POV_WORD_BITS-1:0]  words;
    } column_write_t;

endpackage

//--- hw/pov_drv_pkg.sv
// LED driver side types

`include "pov_defs.svh"

package pov_drv_pkg;

    // All lane words of one column as read from frame memory
    typedef logic [`POV_NUM_LANES-1:0][`POV_WORD_BITS-1:0] column_words_t;

    // Per-cycle strobes from the sequencer to lanes and pin map
    typedef struct packed {
        logic load;
        logic shift_tick;
        logic latch;
    } lane_ctrl_t;

    // Column sequencer FSM
    typedef enum logic [2:0] {
        SQ_IDLE,
        SQ_READ,
        SQ_LOAD,
        SQ_SHIFT,
        SQ_LATCH,
        SQ_NEXT
    } seq_state_e;

endpackage

//--- hw/spi_slave_rx.sv
// SPI mode 0 slave

`timescale 1ns/1ps
`include "pov_defs.svh"

module spi_slave_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       cs_n,
    input  logic       sclk,
    input  logic       mosi,
    output logic       miso,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_start,
    input  logic [7:0] tx_byte
);

    localparam int S = `POV_SYNC_STAGES;

    logic [S-1:0] cs_sync;
    logic [S-1:0] sclk_sync;
    logic [S-1:0] mosi_sync;
    logic         cs_s;
    logic         sclk_s;
    logic         mosi_s;
    logic         cs_prev;
    logic         sclk_prev;
    logic         sclk_rise;
    logic         sclk_fall;
    logic         cs_fall;
    logic [2:0]   bit_cnt;
    logic         load_pending;
    logic [7:0]   rx_sr;
    logic [7:0]   tx_sr;

    // Pin synchronizers, chip select idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            cs_sync   <= '1;
            sclk_sync <= '0;
            mosi_sync <= '0;
            cs_prev   <= 1'b1;
            sclk_prev <= 1'b0;
        end else begin
            cs_sync   <= {cs_sync[S-2:0], cs_n};
            sclk_sync <= {sclk_sync[S-2:0], sclk};
            mosi_sync <= {mosi_sync[S-2:0], mosi};
            cs_prev   <= cs_s;
            sclk_prev <= sclk_s;
        end
    end

    assign cs_s   = cs_sync[S-1];
    assign sclk_s = sclk_sync[S-1];
    assign mosi_s = mosi_sync[S-1];

    // Edges seen only while selected
    assign cs_fall   = cs_prev & ~cs_s;
    assign sclk_rise = ~cs_s & sclk_s & ~sclk_prev;
    assign sclk_fall = ~cs_s & ~sclk_s & sclk_prev;

    // Bit count, strobes and miso
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt      <= '0;
            rx_valid     <= 1'b0;
            frame_start  <= 1'b0;
            load_pending <= 1'b0;
            miso         <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_start <= 1'b0;
            if (cs_s) begin
                bit_cnt      <= '0;
                load_pending <= 1'b0;
                miso         <= 1'b0;
            end else if (cs_fall) begin
                bit_cnt     <= '0;
                frame_start <= 1'b1;
                miso        <= tx_byte[7];
            end else begin
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        rx_valid     <= 1'b1;
                        load_pending <= 1'b1;
                    end
                end
                // Reply byte is taken at the first falling edge after a boundary
                if (sclk_fall) begin
                    miso         <= load_pending ? tx_byte[7] : tx_sr[7];
                    load_pending <= 1'b0;
                end
            end
        end
    end

    // Shift registers carry payload only
    always_ff @(posedge clk) begin
        if (cs_fall) begin
            tx_sr <= {tx_byte[6:0], 1'b0};
        end else if (sclk_fall) begin
            tx_sr <= load_pending ? {tx_byte[6:0], 1'b0} : {tx_sr[6:0], 1'b0};
        end
        if (sclk_rise) begin
            rx_sr <= {rx_sr[6:0], mosi_s};
            if (bit_cnt == 3'd7)
                rx_byte <= {rx_sr[6:0], mosi_s};
        end
    end

endmodule

//--- hw/cmd_decoder.sv
// Host command parser and frame memory

`timescale 1ns/1ps
`include "pov_defs.svh"

module cmd_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 rx_byte,
    input  logic                       rx_valid,
    input  logic                       frame_start,
    output logic [7:0]                 tx_byte,
    input  logic [`POV_COL_BITS-1:0]   rd_column,
    output pov_drv_pkg::column_words_t rd_words,
    output logic [7:0]                 mux_mask,
    input  logic                       frame_done
);

    localparam int BPW        = `POV_WORD_BITS / 8;
    localparam int DATA_BYTES = `POV_NUM_LANES * BPW;
    localparam int IDX_BITS   = $clog2(DATA_BYTES);

    pov_cmd_pkg::parse_state_e  state;
    pov_cmd_pkg::cmd_opcode_e   op;
    pov_cmd_pkg::column_write_t wr;
    logic [IDX_BITS-1:0]        byte_idx;
    logic                       wr_en;
    logic [15:0]                frame_cnt;

    // Frame memory, one entry per column
    pov_drv_pkg::column_words_t mem [`POV_NUM_COLUMNS];

    assign op = pov_cmd_pkg::cmd_opcode_e'(rx_byte);

    // Parser FSM with mask, counter and reply byte
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= pov_cmd_pkg::PS_OPCODE;
            byte_idx  <= '0;
            wr_en     <= 1'b0;
            mux_mask  <= 8'hFF;
            tx_byte   <= 8'h00;
            frame_cnt <= 16'd0;
        end else begin
            wr_en <= 1'b0;
            if (frame_done)
                frame_cnt <= frame_cnt + 16'd1;
            if (frame_start) begin
                // New chip select drops any partial command
                state   <= pov_cmd_pkg::PS_OPCODE;
                tx_byte <= 8'h00;
            end else if (rx_valid) begin
                tx_byte <= 8'h00;
                case (state)
                    pov_cmd_pkg::PS_OPCODE: begin
                        case (op)
                            pov_cmd_pkg::OP_WRITE_COLUMN: state <= pov_cmd_pkg::PS_COLUMN;
                            pov_cmd_pkg::OP_SET_MUX:      state <= pov_cmd_pkg::PS_MASK;
                            pov_cmd_pkg::OP_READ_STATUS: begin
                                state   <= pov_cmd_pkg::PS_STATUS;
                                tx_byte <= frame_cnt[7:0];
                            end
                            default: state <= pov_cmd_pkg::PS_DRAIN;
                        endcase
                    end
                    pov_cmd_pkg::PS_COLUMN: begin
                        byte_idx <= '0;
                        state    <= pov_cmd_pkg::PS_DATA;
                    end
                    pov_cmd_pkg::PS_DATA: begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == IDX_BITS'(DATA_BYTES - 1)) begin
                            wr_en <= 1'b1;
                            state <= pov_cmd_pkg::PS_DRAIN;
                        end
                    end
                    pov_cmd_pkg::PS_MASK: begin
                        mux_mask <= rx_byte;
                        state    <= pov_cmd_pkg::PS_DRAIN;
                    end
                    // Dummy byte of a status read
                    pov_cmd_pkg::PS_STATUS: state <= pov_cmd_pkg::PS_DRAIN;
                    default:                state <= pov_cmd_pkg::PS_DRAIN;
                endcase
            end
        end
    end

    // Entry assembly, MSB byte of each word first, lane 0 first
    always_ff @(posedge clk) begin
        if (rx_valid && !frame_start) begin
            if (state == pov_cmd_pkg::PS_COLUMN)
                wr.column <= rx_byte[`POV_COL_BITS-1:0];
            if (state == pov_cmd_pkg::PS_DATA)
                wr.words[byte_idx / BPW][(BPW - 1 - byte_idx % BPW) * 8 +: 8] <= rx_byte;
        end
    end

    // Whole entry written the cycle after the last data byte
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr.column] <= wr.words;
        rd_words <= mem[rd_column];
    end

endmodule

//--- hw/column_sequencer.sv
// Revolution column sequencer

`timescale 1ns/1ps
`include "pov_defs.svh"

module column_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hall,
    output logic [`POV_COL_BITS-1:0]     rd_column,
    output pov_drv_pkg::lane_ctrl_t      ctrl,
    output logic [`POV_NUM_COLUMNS-1:0]  mux_col,
    input  logic [7:0]                   mux_mask,
    output logic                         frame_done
);

    localparam int S        = `POV_SYNC_STAGES;
    localparam int BIT_BITS = $clog2(`POV_WORD_BITS);

    pov_drv_pkg::seq_state_e  state;
    logic [S-1:0]             hall_sync;
    logic                     hall_prev;
    logic                     hall_rise;
    logic [`POV_COL_BITS-1:0] col;
    logic [BIT_BITS-1:0]      bit_cnt;
    logic                     div;
    logic                     last_col;
    logic                     tick;

    // Hall input synchronizer and rising edge
    always_ff @(posedge clk) begin
        if (rst) begin
            hall_sync <= '0;
            hall_prev <= 1'b0;
        end else begin
            hall_sync <= {hall_sync[S-2:0], hall};
            hall_prev <= hall_sync[S-1];
        end
    end

    assign hall_rise = hall_sync[S-1] & ~hall_prev;
    assign last_col  = (col == `POV_COL_BITS'(`POV_NUM_COLUMNS - 1));

    // Ticks land on every other cycle of SQ_SHIFT, starting with the first
    assign tick = (state == pov_drv_pkg::SQ_SHIFT) && !div;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= pov_drv_pkg::SQ_IDLE;
            col     <= '0;
            bit_cnt <= '0;
            div     <= 1'b0;
        end else begin
            case (state)
                pov_drv_pkg::SQ_IDLE: begin
                    col <= '0;
                    // Pulses outside idle are dropped
                    if (hall_rise)
                        state <= pov_drv_pkg::SQ_READ;
                end
                pov_drv_pkg::SQ_READ: state <= pov_drv_pkg::SQ_LOAD;
                pov_drv_pkg::SQ_LOAD: begin
                    bit_cnt <= '0;
                    div     <= 1'b0;
                    state   <= pov_drv_pkg::SQ_SHIFT;
                end
                pov_drv_pkg::SQ_SHIFT: begin
                    div <= ~div;
                    if (tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_BITS'(`POV_WORD_BITS - 1))
                            state <= pov_drv_pkg::SQ_LATCH;
                    end
                end
                pov_drv_pkg::SQ_LATCH: state <= pov_drv_pkg::SQ_NEXT;
                pov_drv_pkg::SQ_NEXT: begin
                    if (last_col) begin
                        state <= pov_drv_pkg::SQ_IDLE;
                    end else begin
                        col   <= col + 1'b1;
                        state <= pov_drv_pkg::SQ_READ;
                    end
                end
                default: state <= pov_drv_pkg::SQ_IDLE;
            endcase
        end
    end

    // Lane strobes decoded from state
    assign ctrl.load       = (state == pov_drv_pkg::SQ_LOAD);
    assign ctrl.shift_tick = tick;
    assign ctrl.latch      = (state == pov_drv_pkg::SQ_LATCH);

    assign rd_column  = col;
    assign frame_done = (state == pov_drv_pkg::SQ_NEXT) && last_col;

    // One-hot column select gated by host mask
    always_comb begin
        mux_col = '0;
        if (state != pov_drv_pkg::SQ_IDLE)
            mux_col[col] = 1'b1;
        mux_col = mux_col & mux_mask;
    end

endmodule

//--- hw/lane_serializer.sv
// Driver data lane serializer

`timescale 1ns/1ps
`include "pov_defs.svh"

module lane_serializer (
    input  logic                      clk,
    input  logic                      rst,
    input  pov_drv_pkg::lane_ctrl_t   ctrl,
    input  logic [`POV_WORD_BITS-1:0] word,
    output logic                      sin
);

    localparam int CNT_BITS = $clog2(`POV_WORD_BITS) + 1;

    logic [`POV_WORD_BITS-1:0] shreg;
    logic [CNT_BITS-1:0]       cnt;
    logic                      active;

    // Count of bits already taken, full count means empty
    always_ff @(posedge clk) begin
        if (rst)
            cnt <= CNT_BITS'(`POV_WORD_BITS);
        else if (ctrl.load)
            cnt <= '0;
        else if (ctrl.shift_tick && active)
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (ctrl.load)
            shreg <= word;
        else if (ctrl.shift_tick)
            shreg <= {shreg[`POV_WORD_BITS-2:0], 1'b0};
    end

    assign active = (cnt != CNT_BITS'(`POV_WORD_BITS));

    // MSB is waiting before each tick, zero once the word is spent
    assign sin = active & shreg[`POV_WORD_BITS-1];

endmodule

//--- hw/sin_pin_map.sv
// Driver pin mapping and retiming

`timescale 1ns/1ps
`include "pov_defs.svh"

module sin_pin_map (
    input  logic                      clk,
    input  logic                      rst,
    input  pov_drv_pkg::lane_ctrl_t   ctrl,
    input  logic [`POV_NUM_LANES-1:0] lane_sin,
    output logic [`POV_NUM_LANES-1:0] drv_sin,
    output logic                      drv_sclk,
    output logic                      drv_lat
);

    logic [`POV_NUM_LANES-1:0] mapped;
    logic                      tick_d;
    logic                      lat_d;

    // Board routes lanes in reverse, some buffers invert
    always_comb begin
        for (int i = 0; i < `POV_NUM_LANES; i++)
            mapped[`POV_NUM_LANES-1-i] = lane_sin[i];
        mapped = mapped ^ `POV_SIN_INVERT;
    end

    // Data moves on the tick, clock rises a cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            drv_sin  <= `POV_SIN_INVERT;
            tick_d   <= 1'b0;
            drv_sclk <= 1'b0;
            lat_d    <= 1'b0;
            drv_lat  <= 1'b0;
        end else begin
            if (ctrl.shift_tick)
                drv_sin <= mapped;
            tick_d   <= ctrl.shift_tick;
            drv_sclk <= tick_d;
            lat_d    <= ctrl.latch;
            drv_lat  <= lat_d;
        end
    end

endmodule

//--- hw/pov_display_top.sv
// POV display refresh top level

`timescale 1ns/1ps
`include "pov_defs.svh"

module pov_display_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cs_n,
    input  logic                        sclk,
    input  logic                        mosi,
    output logic                        miso,
    input  logic                        hall,
    output logic [`POV_NUM_LANES-1:0]   drv_sin,
    output logic                        drv_sclk,
    output logic                        drv_lat,
    output logic [`POV_NUM_COLUMNS-1:0] mux_col
);

    // Host byte link
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       frame_start;
    logic [7:0] tx_byte;

    // Frame memory read and control
    logic [`POV_COL_BITS-1:0]   rd_column;
    pov_drv_pkg::column_words_t rd_words;
    logic [7:0]                 mux_mask;
    logic                       frame_done;

    // Lane strobes and serial outputs
    pov_drv_pkg::lane_ctrl_t    ctrl;
    logic [`POV_NUM_LANES-1:0]  lane_sin;

    spi_slave_rx u_spi (
        .clk(clk), .rst(rst), .cs_n(cs_n), .sclk(sclk), .mosi(mosi), .miso(miso),
        .rx_byte(rx_byte), .rx_valid(rx_valid), .frame_start(frame_start),
        .tx_byte(tx_byte)
    );

    cmd_decoder u_dec (
        .clk(clk), .rst(rst), .rx_byte(rx_byte), .rx_valid(rx_valid),
        .frame_start(frame_start), .tx_byte(tx_byte), .rd_column(rd_column),
        .rd_words(rd_words), .mux_mask(mux_mask), .frame_done(frame_done)
    );

    column_sequencer u_seq (
        .clk(clk), .rst(rst), .hall(hall), .rd_column(rd_column), .ctrl(ctrl),
        .mux_col(mux_col), .mux_mask(mux_mask), .frame_done(frame_done)
    );

    // One serializer per driver data line
    for (genvar i = 0; i < `POV_NUM_LANES; i++) begin : g_lane
        lane_serializer u_lane (
            .clk(clk), .rst(rst), .ctrl(ctrl), .word(rd_words[i]), .sin(lane_sin[i])
        );
    end

    sin_pin_map u_pins (
        .clk(clk), .rst(rst), .ctrl(ctrl), .lane_sin(lane_sin),
        .drv_sin(drv_sin), .drv_sclk(drv_sclk), .drv_lat(drv_lat)
    );

endmodule

//--- tests/pov_display_properties.sv
// Driver pin assertions

`timescale 1ns/1ps
`include "pov_defs.svh"

module pov_display_properties (
    input logic                        clk,
    input logic                        rst,
    input logic                        drv_sclk,
    input logic                        drv_lat,
    input logic [`POV_NUM_COLUMNS-1:0] mux_col
);

    int         fail_cnt = 0;
    logic       sclk_prev;
    logic [7:0] sclk_cnt;

    // Serial clock rises since the last latch
    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_prev <= 1'b0;
            sclk_cnt  <= '0;
        end else begin
            sclk_prev <= drv_sclk;
            if (drv_lat)
                sclk_cnt <= '0;
            else if (drv_sclk && !sclk_prev)
                sclk_cnt <= sclk_cnt + 8'd1;
        end
    end

    lat_one_cycle: assert property (@(posedge clk) disable iff (rst) drv_lat |=> !drv_lat)
        else begin
            $error("drv_lat high for more than one cycle");
            fail_cnt++;
        end

    lat_sclk_apart: assert property (@(posedge clk) disable iff (rst) !(drv_lat && drv_sclk))
        else begin
            $error("drv_lat and drv_sclk high together");
            fail_cnt++;
        end

    // Column mux drives at most one column
    mux_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(mux_col))
        else begin
            $error("mux_col has more than one bit set");
            fail_cnt++;
        end

    lat_after_word: assert property (@(posedge clk) disable iff (rst)
        drv_lat |-> sclk_cnt == 8'(`POV_WORD_BITS))
        else begin
            $error("wrong number of drv_sclk pulses before drv_lat");
            fail_cnt++;
        end

endmodule

bind pov_display_top pov_display_properties u_props (
    .clk(clk), .rst(rst), .drv_sclk(drv_sclk), .drv_lat(drv_lat), .mux_col(mux_col)
);

//--- tests/pov_display_tb.sv
// POV display testbench

`timescale 1ns/1ps
`include "pov_defs.svh"

module pov_display_tb;

    localparam int LANES = `POV_NUM_LANES;
    localparam int BITS  = `POV_WORD_BITS;
    localparam int COLS  = `POV_NUM_COLUMNS;
    // 5 revolutions of about 290 cycles plus 109 SPI bytes of 64 cycles, about 9000, with margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                clk;
    logic                rst;
    logic                cs_n;
    logic                sclk;
    logic                mosi;
    logic                miso;
    logic                hall;
    logic [LANES-1:0]    drv_sin;
    logic                drv_sclk;
    logic                drv_lat;
    logic [COLS-1:0]     mux_col;

    // Host view of frame memory and mask
    logic [BITS-1:0]     model [COLS][LANES];
    logic [7:0]          mask_model;
    int                  revs = 0;
    int                  errors = 0;
    int                  cols_checked = 0;
    int                  cycles = 0;

    // Pin monitor state
    logic [LANES-1:0][BITS-1:0] pin_acc;
    int                         bits_seen = 0;
    logic [7:0]                 first_mux;
    logic [LANES-1:0][BITS-1:0] got_q [$];
    logic [7:0]                 mux_q [$];

    pov_display_top u_pov_display_top (
        .clk(clk), .rst(rst), .cs_n(cs_n), .sclk(sclk), .mosi(mosi), .miso(miso),
        .hall(hall), .drv_sin(drv_sin), .drv_sclk(drv_sclk), .drv_lat(drv_lat),
        .mux_col(mux_col)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, DUT stopped producing columns", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Pin word from model memory, lane reversal and buffer inversion
    function automatic logic [BITS-1:0] expected_pins(input int col, input int pin);
        logic [LANES-1:0] inv;
        logic [BITS-1:0]  w;
        inv = `POV_SIN_INVERT;
        w   = model[col][LANES-1-pin];
        return inv[pin] ? ~w : w;
    endfunction

    // Data is settled a cycle before each rising drv_sclk
    always @(posedge drv_sclk or posedge drv_lat) begin
        if (drv_lat) begin
            got_q.push_back(pin_acc);
            mux_q.push_back(first_mux);
            bits_seen = 0;
        end else begin
            // Sequencer stays in the shift state here, so mux_col is steady
            if (bits_seen == 0)
                first_mux = mux_col;
            for (int p = 0; p < LANES; p++)
                pin_acc[p] = {pin_acc[p][BITS-2:0], drv_sin[p]};
            bits_seen++;
        end
    end

    // Compare each latched column in revolution order
    initial begin
        logic [LANES-1:0][BITS-1:0] got;
        logic [7:0]                 mux_got;
        logic [7:0]                 mux_exp;
        int                         col;
        forever begin
            while (got_q.size() == 0)
                @(posedge clk);
            got     = got_q.pop_front();
            mux_got = mux_q.pop_front();
            col     = cols_checked % COLS;
            for (int p = 0; p < LANES; p++) begin
                assert (got[p] == expected_pins(col, p)) else begin
                    errors++;
                    $display("FAIL %0t: column %0d pin %0d got %h expected %h",
                             $time, col, p, got[p], expected_pins(col, p));
                end
            end
            mux_exp = (8'd1 << col) & mask_model;
            assert (mux_got == mux_exp) else begin
                errors++;
                $display("FAIL %0t: column %0d mux_col %b expected %b",
                         $time, col, mux_got, mux_exp);
            end
            cols_checked++;
        end
    end

    // One byte each way, sclk edge every four clocks
    task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            @(posedge clk);
            sclk <= 1'b0;
            mosi <= tx[i];
            repeat (3) @(posedge clk);
            @(posedge clk);
            sclk  <= 1'b1;
            rx[i] = miso;
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic cs_begin();
        @(posedge clk);
        cs_n <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic cs_end();
        @(posedge clk);
        sclk <= 1'b0;
        repeat (4) @(posedge clk);
        cs_n <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic write_column(input int col, input int extra);
        logic [7:0] rx;
        cs_begin();
        spi_xfer(`POV_OP_WRITE_COLUMN, rx);
        spi_xfer(8'(col), rx);
        for (int l = 0; l < LANES; l++) begin
            spi_xfer(model[col][l][BITS-1 -: 8], rx);
            spi_xfer(model[col][l][7:0], rx);
        end
        // Trailing bytes beyond the command
        for (int e = 0; e < extra; e++)
            spi_xfer(8'($urandom), rx);
        cs_end();
    endtask

    task automatic set_mask(input logic [7:0] m);
        logic [7:0] rx;
        cs_begin();
        spi_xfer(`POV_OP_SET_MUX, rx);
        spi_xfer(m, rx);
        cs_end();
        mask_model = m;
    endtask

    task automatic check_status();
        logic [7:0] rx;
        logic [7:0] st;
        cs_begin();
        spi_xfer(`POV_OP_READ_STATUS, rx);
        spi_xfer(8'h00, st);
        cs_end();
        assert (st == 8'(revs)) else begin
            errors++;
            $display("FAIL %0t: status %0d expected %0d", $time, st, 8'(revs));
        end
    endtask

    task automatic hall_pulse();
        @(posedge clk);
        hall <= 1'b1;
        repeat (4) @(posedge clk);
        hall <= 1'b0;
    endtask

    task automatic run_revolution(input bit extra_pulse);
        int target;
        target = cols_checked + COLS;
        hall_pulse();
        // A pulse mid revolution must not restart the columns
        if (extra_pulse) begin
            repeat (100) @(posedge clk);
            hall_pulse();
        end
        while (cols_checked < target)
            @(posedge clk);
        repeat (10) @(posedge clk);
        revs++;
    endtask

    initial begin
        logic [7:0] rx;
        int         total;
        rst        = 1'b1;
        cs_n       = 1'b1;
        sclk       = 1'b0;
        mosi       = 1'b0;
        hall       = 1'b0;
        void'($urandom(32'h62b5d454));
        mask_model = 8'hFF;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // Quiet outputs and zero counter after reset
        assert (!drv_lat && !drv_sclk && mux_col == '0 && !miso) else begin
            errors++;
            $display("FAIL %0t: outputs not idle after reset", $time);
        end
        check_status();

        // Fill all columns, then one revolution
        for (int c = 0; c < COLS; c++) begin
            for (int l = 0; l < LANES; l++)
                model[c][l] = BITS'($urandom);
            write_column(c, 0);
        end
        run_revolution(0);

        set_mask(8'($urandom));
        run_revolution(0);
        check_status();

        // Stray hall pulse is not counted
        run_revolution(1);
        run_revolution(0);
        check_status();

        // Extra bytes after a write, then an aborted write to column 5
        for (int l = 0; l < LANES; l++)
            model[3][l] = BITS'($urandom);
        write_column(3, 3);
        cs_begin();
        spi_xfer(`POV_OP_WRITE_COLUMN, rx);
        spi_xfer(8'd5, rx);
        spi_xfer(8'($urandom), rx);
        spi_xfer(8'($urandom), rx);
        cs_end();
        set_mask(8'hFF);
        run_revolution(0);
        check_status();

        total = errors + u_pov_display_top.u_props.fail_cnt;
        $display("Summary: %0d columns, %0d check errors, %0d assertion failures",
                 cols_checked, errors, u_pov_display_top.u_props.fail_cnt);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+hw
hw/pov_cmd_pkg.sv
hw/pov_drv_pkg.sv
hw/spi_slave_rx.sv
hw/cmd_decoder.sv
hw/column_sequencer.sv
hw/lane_serializer.sv
hw/sin_pin_map.sv
hw/pov_display_top.sv
tests/pov_display_properties.sv
tests/pov_display_tb.sv
